/* sim.f */
+incdir+common
common/hdc_pkg.sv
logic/item_memory.sv
logic/inst_decoder.sv
logic/thread_regfile.sv
logic/exec_unit.sv
logic/hdc_core.sv
sim/hdc_properties.sv
sim/hdc_checker.sv
sim/hdc_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module hdc_tb -o hdc_sim
./obj_dir/hdc_sim | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* sim/hdc_tb.sv */
`timescale 1ns/1ps

`include "hdc_consts.svh"

module hdc_tb;

    // instructions issued over all tests, rounded up
    localparam int PLANNED_INSTS = 130;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   run;
    logic                   gen;
    logic                   update_item;
    hdc_pkg::item_addr_t    item_addr;
    hdc_pkg::hv_t           rand_vec;
    logic                   inst_valid;
    logic [`HDC_INST_W-1:0] inst_word;
    hdc_pkg::hv_t           sign_vec;
    logic                   store;
    hdc_pkg::hv_t           core_result;
    logic                   last;

    // reference state
    hdc_pkg::hv_t           mem_model [0:`HDC_MEM_DEPTH-1];
    hdc_pkg::hv_t           r1_model [0:`HDC_THREADS-1];
    hdc_pkg::hv_t           r2_model [0:`HDC_THREADS-1];
    int                     thread_model;
    int                     slot_count;
    logic                   pend_valid;
    logic [`HDC_INST_W-1:0] pend_word;

    logic [31:0]            lfsr_state = 32'h4ec9;
    hdc_pkg::hv_t           rnd;
    hdc_pkg::hv_t           sign_next;
    hdc_pkg::item_addr_t    addr_list [0:15];
    int                     tb_errors = 0;
    int                     errs_mark = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    int                     total;

    always #5 clk = ~clk;

    hdc_core UUT (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .gen         (gen),
        .update_item (update_item),
        .item_addr   (item_addr),
        .rand_vec    (rand_vec),
        .inst_valid  (inst_valid),
        .inst_word   (inst_word),
        .sign_vec    (sign_vec),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

    hdc_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

    bind hdc_core hdc_properties u_props (
        .clk         (clk),
        .reset       (reset),
        .store       (store),
        .last        (last),
        .core_result (core_result)
    );

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output hdc_pkg::hv_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [`HDC_INST_W-1:0] make_word(input logic [3:0] code,
                                                         input hdc_pkg::item_addr_t a);
        logic [`HDC_INST_W-1:0] w;
        w = '0;
        w[`HDC_OP_MSB:`HDC_OP_LSB] = code;
        w[`HDC_ADDR_MSB:`HDC_ADDR_LSB] = a;
        return w;
    endfunction

    // one instruction on the model, returns reg2 for a store
    function automatic hdc_pkg::hv_t ref_exec(input logic [`HDC_INST_W-1:0] word,
                                              input hdc_pkg::hv_t sgn);
        logic [3:0]          code;
        hdc_pkg::item_addr_t a;
        int                  t;
        hdc_pkg::hv_t        res;
        code = word[`HDC_OP_MSB:`HDC_OP_LSB];
        a = word[`HDC_ADDR_MSB:`HDC_ADDR_LSB];
        t = thread_model;
        res = '0;
        case (code)
            hdc_pkg::op_load:    r2_model[t] = mem_model[a];
            hdc_pkg::op_xor:     r2_model[t] = r1_model[t] ^ r2_model[t];
            hdc_pkg::op_store:   res = r2_model[t];
            hdc_pkg::op_move:    r1_model[t] = r2_model[t];
            hdc_pkg::op_sign:    r2_model[t] = sgn;
            hdc_pkg::op_wb_item: mem_model[a] = r2_model[t];
            default: ;
        endcase
        thread_model = (t + 1) % `HDC_THREADS;
        return res;
    endfunction

    function automatic void clear_model();
        for (int t = 0; t < `HDC_THREADS; t++) begin
            r1_model[t] = '0;
            r2_model[t] = '0;
        end
        thread_model = 0;
        slot_count = 0;
        pend_valid = 1'b0;
    endfunction

    task automatic drive_cycle(input logic valid, input logic [`HDC_INST_W-1:0] word,
                               input logic fill, input hdc_pkg::item_addr_t faddr,
                               input hdc_pkg::hv_t fvec);
        hdc_pkg::hv_t res;
        logic [3:0]   pend_code;
        logic         wb_now;
        @(negedge clk);
        inst_valid = valid;
        inst_word = word;
        sign_vec = sign_next;
        gen = fill;
        update_item = fill;
        item_addr = faddr;
        rand_vec = fvec;
        // previous instruction is in its execute cycle now
        pend_code = pend_word[`HDC_OP_MSB:`HDC_OP_LSB];
        wb_now = pend_valid && (pend_code == hdc_pkg::op_wb_item);
        if (pend_valid) begin
            res = ref_exec(pend_word, sign_vec);
            if (pend_code == hdc_pkg::op_store) begin
                u_checker.push_store(res);
            end
            if (pend_code == hdc_pkg::op_last) begin
                u_checker.push_last();
            end
        end
        // a fill beside a write-back is lost
        if (fill && !wb_now) begin
            mem_model[faddr] = fvec;
        end
        pend_valid = valid && run;
        pend_word = word;
        if (valid && run) begin
            slot_count++;
        end
    endtask

    task automatic issue(input logic [3:0] code, input hdc_pkg::item_addr_t a);
        drive_cycle(1'b1, make_word(code, a), 1'b0, '0, '0);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    // one instruction per thread, address from addr_list[base + thread]
    task automatic issue_round(input logic [3:0] code, input int base);
        for (int t = 0; t < `HDC_THREADS; t++) begin
            issue(code, addr_list[base + t]);
        end
    endtask

    task automatic round_fresh_sign(input logic [3:0] code);
        for (int t = 0; t < `HDC_THREADS; t++) begin
            take_bits(`HDC_HV_WIDTH, sign_next);
            issue(code, '0);
        end
    endtask

    task automatic align_threads();
        while (slot_count % `HDC_THREADS != 0) begin
            issue(hdc_pkg::op_nop, '0);
        end
    endtask

    task automatic stop_run();
        idle(2);
        @(negedge clk);
        run = 1'b0;
        clear_model();
    endtask

    task automatic start_run();
        @(negedge clk);
        inst_valid = 1'b0;
        run = 1'b1;
    endtask

    task automatic end_test(input string name);
        int errs;
        idle(2);
        for (int i = 0; i < 20 && u_checker.outstanding() != 0; i++) begin
            @(negedge clk);
        end
        if (u_checker.outstanding() != 0) begin
            tb_errors++;
            $display("error: test %0s ended with %0d expected outputs that never appeared",
                     name, u_checker.outstanding());
        end
        errs = tb_errors + u_checker.error_count - errs_mark;
        errs_mark = errs_mark + errs;
        tests_run++;
        if (errs == 0) begin
            $display("test %0s: passed", name);
        end else begin
            tests_failed++;
            $display("test %0s: failed with %0d errors", name, errs);
        end
    endtask

    initial begin
        reset = 1'b1;
        run = 1'b0;
        gen = 1'b0;
        update_item = 1'b0;
        item_addr = '0;
        rand_vec = '0;
        inst_valid = 1'b0;
        inst_word = '0;
        sign_vec = '0;
        sign_next = '0;
        pend_word = '0;
        clear_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run = 1'b1;

        // fill 16 distinct addresses, then load and store per thread
        for (int i = 0; i < 16; i++) begin
            take_bits(2, rnd);
            addr_list[i] = {rnd[1:0], 4'(i)};
            take_bits(`HDC_HV_WIDTH, rnd);
            drive_cycle(1'b0, '0, 1'b1, addr_list[i], rnd);
        end
        issue_round(hdc_pkg::op_load, 0);
        issue_round(hdc_pkg::op_store, 0);
        issue_round(hdc_pkg::op_load, 5);
        issue_round(hdc_pkg::op_store, 5);
        end_test("fill_load");

        // a xor b on every thread
        align_threads();
        issue_round(hdc_pkg::op_load, 0);
        issue_round(hdc_pkg::op_move, 0);
        issue_round(hdc_pkg::op_load, 5);
        issue_round(hdc_pkg::op_xor, 0);
        issue_round(hdc_pkg::op_store, 0);
        end_test("bind");

        align_threads();
        round_fresh_sign(hdc_pkg::op_sign);
        round_fresh_sign(hdc_pkg::op_store);
        end_test("sign");

        // wb on slots 0 2 4 6 8 covers threads 0 2 4 1 3, fill rides in the wb cycle
        align_threads();
        round_fresh_sign(hdc_pkg::op_sign);
        for (int i = 0; i < `HDC_THREADS; i++) begin
            issue(hdc_pkg::op_wb_item, addr_list[11 + (2 * i) % `HDC_THREADS]);
            take_bits(`HDC_HV_WIDTH, rnd);
            drive_cycle(1'b1, make_word(hdc_pkg::op_nop, '0), 1'b1,
                        addr_list[(2 * i) % `HDC_THREADS], rnd);
        end
        issue_round(hdc_pkg::op_load, 11);
        issue_round(hdc_pkg::op_store, 0);
        issue_round(hdc_pkg::op_load, 0);
        issue_round(hdc_pkg::op_store, 0);
        end_test("write_back");

        // odd threads get an unused code, which is a nop
        align_threads();
        issue_round(hdc_pkg::op_load, 6);
        for (int t = 0; t < `HDC_THREADS; t++) begin
            issue((t % 2 == 0) ? 4'(hdc_pkg::op_xor) : 4'hb, '0);
        end
        issue_round(hdc_pkg::op_store, 0);
        stop_run();
        repeat (3) issue(hdc_pkg::op_load, addr_list[2]);
        start_run();
        issue_round(hdc_pkg::op_store, 0);
        end_test("isolate_clear");

        align_threads();
        issue(hdc_pkg::op_store, '0);
        issue(hdc_pkg::op_last, '0);
        issue(hdc_pkg::op_nop, '0);
        issue(hdc_pkg::op_last, '0);
        end_test("last");

        total = tb_errors + u_checker.error_count;
        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, total);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // 50 cycles for each planned instruction
    initial begin
        repeat (PLANNED_INSTS * 50) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", PLANNED_INSTS * 50);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* sim/hdc_checker.sv */
`timescale 1ns/1ps

module hdc_checker (
    input logic         clk,
    input logic         reset,
    input logic         store,
    input hdc_pkg::hv_t core_result,
    input logic         last
);

    hdc_pkg::hv_t exp_store [$];
    hdc_pkg::hv_t head;
    int           exp_last = 0;
    int           error_count = 0;

    task automatic push_store(input hdc_pkg::hv_t v);
        exp_store.push_back(v);
    endtask

    task automatic push_last();
        exp_last++;
    endtask

    function automatic int outstanding();
        return exp_store.size() + exp_last;
    endfunction

    // outputs change on the rising edge, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && store) begin
            if (exp_store.size() == 0) begin
                error_count++;
                $display("error at %0t: store pulse with no store instruction behind it",
                         $time);
            end else begin
                head = exp_store.pop_front();
                if (core_result !== head) begin
                    error_count++;
                    $display("mismatch at %0t: core_result expected %h got %h",
                             $time, head, core_result);
                end
            end
        end
        if (!reset && last) begin
            if (store) begin
                error_count++;
                $display("error at %0t: store and last high in the same cycle", $time);
            end
            if (exp_last == 0) begin
                error_count++;
                $display("error at %0t: last pulse with no last instruction behind it",
                         $time);
            end else begin
                exp_last--;
            end
        end
    end

endmodule

/* sim/hdc_properties.sv */
`timescale 1ns/1ps

module hdc_properties (
    input logic         clk,
    input logic         reset,
    input logic         store,
    input logic         last,
    input hdc_pkg::hv_t core_result
);

    // outputs settle one edge into reset
    a_quiet_in_reset: assert property (
        @(posedge clk) (reset && $past(reset)) |-> (!store && !last)
    ) else $error("store or last high during reset");

    a_result_gated: assert property (
        @(posedge clk) !store |-> (core_result == '0)
    ) else $error("core_result nonzero while store is low");

    a_no_joint_rise: assert property (
        @(posedge clk) disable iff (reset) !($rose(store) && $rose(last))
    ) else $error("store and last rose in the same cycle");

endmodule

/* logic/hdc_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    run,

    // item memory fill
    input  logic                    gen,
    input  logic                    update_item,
    input  hdc_pkg::item_addr_t     item_addr,
    input  hdc_pkg::hv_t            rand_vec,

    // instruction stream
    input  logic                    inst_valid,
    input  logic [`HDC_INST_W-1:0]  inst_word,
    input  hdc_pkg::hv_t            sign_vec,

    output logic                    store,
    output hdc_pkg::hv_t            core_result,
    output logic                    last
);

    hdc_pkg::item_addr_t rd_addr;
    hdc_pkg::hv_t        rd_data;

    logic                exe_valid;
    hdc_pkg::opcode_t    exe_op;
    hdc_pkg::thread_t    exe_thread;
    hdc_pkg::item_addr_t exe_addr;

    hdc_pkg::hv_t        reg1;
    hdc_pkg::hv_t        reg2;

    logic                r1_we;
    logic                r2_we;
    hdc_pkg::hv_t        r2_wdata;

    logic                wb_we;
    hdc_pkg::item_addr_t wb_addr;
    hdc_pkg::hv_t        wb_data;

    inst_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .rd_addr    (rd_addr),
        .exe_valid  (exe_valid),
        .exe_op     (exe_op),
        .exe_thread (exe_thread),
        .exe_addr   (exe_addr)
    );

    item_memory u_item_mem (
        .clk         (clk),
        .gen         (gen),
        .update_item (update_item),
        .item_addr   (item_addr),
        .rand_vec    (rand_vec),
        .wb_we       (wb_we),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    thread_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .exe_thread (exe_thread),
        .r1_we      (r1_we),
        .r2_we      (r2_we),
        .r2_wdata   (r2_wdata),
        .reg1       (reg1),
        .reg2       (reg2)
    );

    exec_unit u_exec (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .exe_valid   (exe_valid),
        .exe_op      (exe_op),
        .exe_addr    (exe_addr),
        .rd_data     (rd_data),
        .reg1        (reg1),
        .reg2        (reg2),
        .sign_vec    (sign_vec),
        .r1_we       (r1_we),
        .r2_we       (r2_we),
        .r2_wdata    (r2_wdata),
        .wb_we       (wb_we),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,

    // decoded instruction
    input  logic                exe_valid,
    input  hdc_pkg::opcode_t    exe_op,
    input  hdc_pkg::item_addr_t exe_addr,

    // operands
    input  hdc_pkg::hv_t        rd_data,
    input  hdc_pkg::hv_t        reg1,
    input  hdc_pkg::hv_t        reg2,
    input  hdc_pkg::hv_t        sign_vec,

    // register write-back
    output logic                r1_we,
    output logic                r2_we,
    output hdc_pkg::hv_t        r2_wdata,

    // item memory write-back
    output logic                wb_we,
    output hdc_pkg::item_addr_t wb_addr,
    output hdc_pkg::hv_t        wb_data,

    // core outputs
    output logic                store,
    output hdc_pkg::hv_t        core_result,
    output logic                last
);

    logic         is_store;
    logic         is_last;
    hdc_pkg::hv_t store_buf;

    always_comb begin
        r1_we    = 1'b0;
        r2_we    = 1'b0;
        wb_we    = 1'b0;
        r2_wdata = rd_data;
        if (exe_valid) begin
            case (exe_op)
                hdc_pkg::op_load: begin
                    r2_we    = 1'b1;
                    r2_wdata = rd_data;
                end
                // bind
                hdc_pkg::op_xor: begin
                    r2_we    = 1'b1;
                    r2_wdata = reg1 ^ reg2;
                end
                hdc_pkg::op_sign: begin
                    r2_we    = 1'b1;
                    r2_wdata = sign_vec;
                end
                hdc_pkg::op_move: begin
                    r1_we = 1'b1;
                end
                hdc_pkg::op_wb_item: begin
                    wb_we = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    assign wb_addr = exe_addr;
    assign wb_data = reg2;

    assign is_store = exe_valid && (exe_op == hdc_pkg::op_store);
    assign is_last  = exe_valid && (exe_op == hdc_pkg::op_last);

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            store <= 1'b0;
            last  <= 1'b0;
        end else begin
            store <= is_store;
            last  <= is_last;
        end
    end

    // captured reg2, only shown while store is high
    always_ff @(posedge clk) begin
        if (is_store) begin
            store_buf <= reg2;
        end
    end

    assign core_result = store ? store_buf : '0;

endmodule

`default_nettype wire

/* logic/thread_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module thread_regfile (
    input  logic             clk,
    input  logic             reset,
    input  logic             run,

    // thread of the instruction in execute
    input  hdc_pkg::thread_t exe_thread,

    // write port
    input  logic             r1_we,
    input  logic             r2_we,
    input  hdc_pkg::hv_t     r2_wdata,

    // read port
    output hdc_pkg::hv_t     reg1,
    output hdc_pkg::hv_t     reg2
);

    hdc_pkg::hv_t reg1_bank [0:`HDC_THREADS-1];
    hdc_pkg::hv_t reg2_bank [0:`HDC_THREADS-1];

    // read mux, an index past the last thread reads zero
    always_comb begin
        reg1 = '0;
        reg2 = '0;
        for (int t = 0; t < `HDC_THREADS; t++) begin
            if (exe_thread == hdc_pkg::thread_t'(t)) begin
                reg1 = reg1_bank[t];
                reg2 = reg2_bank[t];
            end
        end
    end

    // all threads cleared whenever the core is stopped
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            for (int t = 0; t < `HDC_THREADS; t++) begin
                reg1_bank[t] <= '0;
                reg2_bank[t] <= '0;
            end
        end else begin
            for (int t = 0; t < `HDC_THREADS; t++) begin
                if (exe_thread == hdc_pkg::thread_t'(t)) begin
                    // move copies the current reg2 into reg1
                    if (r1_we) begin
                        reg1_bank[t] <= reg2_bank[t];
                    end
                    if (r2_we) begin
                        reg2_bank[t] <= r2_wdata;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module inst_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    run,

    // instruction stream, no back-pressure
    input  logic                    inst_valid,
    input  logic [`HDC_INST_W-1:0]  inst_word,

    // item memory read address, taken straight from the word
    output hdc_pkg::item_addr_t     rd_addr,

    // decoded instruction for the execute cycle
    output logic                    exe_valid,
    output hdc_pkg::opcode_t        exe_op,
    output hdc_pkg::thread_t        exe_thread,
    output hdc_pkg::item_addr_t     exe_addr
);

    logic [3:0]          op_field;
    hdc_pkg::opcode_t    dec_op;
    hdc_pkg::item_addr_t addr_field;
    hdc_pkg::thread_t    thread_cnt;
    logic                accept;

    assign op_field   = inst_word[`HDC_OP_MSB:`HDC_OP_LSB];
    assign addr_field = inst_word[`HDC_ADDR_MSB:`HDC_ADDR_LSB];
    assign rd_addr    = addr_field;

    // words are dropped while the core is stopped
    assign accept = inst_valid & run;

    always_comb begin
        case (op_field)
            4'd1:    dec_op = hdc_pkg::op_load;
            4'd2:    dec_op = hdc_pkg::op_xor;
            4'd3:    dec_op = hdc_pkg::op_store;
            4'd4:    dec_op = hdc_pkg::op_move;
            4'd5:    dec_op = hdc_pkg::op_last;
            4'd6:    dec_op = hdc_pkg::op_sign;
            4'd7:    dec_op = hdc_pkg::op_wb_item;
            default: dec_op = hdc_pkg::op_nop;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            exe_valid  <= 1'b0;
            exe_op     <= hdc_pkg::op_nop;
            exe_thread <= '0;
            thread_cnt <= '0;
        end else begin
            exe_valid <= accept;
            if (accept) begin
                exe_op     <= dec_op;
                exe_thread <= thread_cnt;
                // round robin over the threads
                if (thread_cnt == hdc_pkg::thread_t'(`HDC_THREADS - 1)) begin
                    thread_cnt <= '0;
                end else begin
                    thread_cnt <= thread_cnt + 1'b1;
                end
            end
        end
    end

    // address only matters while exe_valid is high
    always_ff @(posedge clk) begin
        if (accept) begin
            exe_addr <= addr_field;
        end
    end

endmodule

`default_nettype wire

/* logic/item_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module item_memory (
    input  logic                clk,

    // random fill
    input  logic                gen,
    input  logic                update_item,
    input  hdc_pkg::item_addr_t item_addr,
    input  hdc_pkg::hv_t        rand_vec,

    // write-back from the execute stage
    input  logic                wb_we,
    input  hdc_pkg::item_addr_t wb_addr,
    input  hdc_pkg::hv_t        wb_data,

    // read side
    input  hdc_pkg::item_addr_t rd_addr,
    output hdc_pkg::hv_t        rd_data
);

    hdc_pkg::hv_t mem [0:`HDC_MEM_DEPTH-1];

    logic                fill_we;
    logic                wr_en;
    hdc_pkg::item_addr_t wr_addr;
    hdc_pkg::hv_t        wr_data;

    assign fill_we = gen & update_item;

    // single write port, write-back wins over a fill in the same cycle
    always_comb begin
        wr_en   = wb_we | fill_we;
        wr_addr = item_addr;
        wr_data = rand_vec;
        if (wb_we) begin
            wr_addr = wb_addr;
            wr_data = wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read every cycle, old data on a same-address collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* common/hdc_pkg.sv */
`include "hdc_consts.svh"

package hdc_pkg;

    // one hypervector
    typedef logic [`HDC_HV_WIDTH-1:0] hv_t;

    // item memory address
    typedef logic [`HDC_ADDR_W-1:0] item_addr_t;

    // thread index
    typedef logic [`HDC_THREAD_W-1:0] thread_t;

    // instruction opcodes, codes 8 to 15 are treated as nop
    typedef enum logic [3:0] {
        op_nop     = 4'd0,
        op_load    = 4'd1,
        op_xor     = 4'd2,
        op_store   = 4'd3,
        op_move    = 4'd4,
        op_last    = 4'd5,
        op_sign    = 4'd6,
        op_wb_item = 4'd7
    } opcode_t;

endpackage

/* common/hdc_consts.svh */
`ifndef HDC_CONSTS_SVH
`define HDC_CONSTS_SVH

// hypervector width, cut down for simulation (1024 on the board)
`define HDC_HV_WIDTH   64
`define HDC_MEM_DEPTH  64
`define HDC_ADDR_W     6

// interleaved threads and the index width
`define HDC_THREADS    5
`define HDC_THREAD_W   3

// instruction word layout
`define HDC_INST_W     16
`define HDC_OP_MSB     15
`define HDC_OP_LSB     12
`define HDC_ADDR_MSB   5
`define HDC_ADDR_LSB   0

`endif
